//--- hw/keyer_pkg.sv
package keyer_pkg;

  // ==================================================
  // widths
  // ==================================================

  // raster coordinate, covers 1280 columns
  localparam int COORD_W = 11;
  // one color channel
  localparam int COLOR_W = 8;
  // per-frame coordinate sums and pixel count
  localparam int SUM_W = 32;
  // center message: x low, x high, y low, y high
  localparam int MSG_BYTES = 4;

  // ==================================================
  // pixel formats and colors
  // ==================================================

  // camera pixel, 5/6/5
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // output pixel, red in the top byte
  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb888_t;

  localparam rgb888_t CROSSHAIR_COLOR = 24'hFF0000;
  localparam rgb888_t MASK_ON_COLOR = 24'hFFFFFF;
  localparam rgb888_t MASK_OFF_COLOR = 24'h000000;

  // ==================================================
  // enums
  // ==================================================

  // display view, set from the switches
  typedef enum logic [1:0] {
    VIEW_CAMERA = 2'b00,
    VIEW_MASK   = 2'b01,
    VIEW_CHROMA = 2'b10,
    VIEW_BLANK  = 2'b11
  } view_sel_e;

  // centroid divider
  typedef enum logic [1:0] {DIV_IDLE, DIV_X, DIV_Y, DIV_DONE} div_state_e;

  // uart serializer
  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage

//--- hw/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720,
  parameter int H_TOTAL = 1650,
  parameter int V_TOTAL = 750
) (
  input  logic                         clk_pixel,
  input  logic                         recent_reset,
  output logic [keyer_pkg::COORD_W-1:0] hcount_o,
  output logic [keyer_pkg::COORD_W-1:0] vcount_o,
  output logic                         active_o,
  output logic                         frame_end_o
);

  // end of line and end of frame
  logic h_last;
  logic v_last;

  assign h_last = (hcount_o == keyer_pkg::COORD_W'(H_TOTAL - 1));
  assign v_last = (vcount_o == keyer_pkg::COORD_W'(V_TOTAL - 1));

  // horizontal counter, wraps at H_TOTAL
  // vertical counter steps once per line
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hcount_o <= '0;
      vcount_o <= '0;
    end else begin
      if (h_last) begin
        hcount_o <= '0;
        if (v_last) begin
          vcount_o <= '0;
        end else begin
          vcount_o <= vcount_o + 1'b1;
        end
      end else begin
        hcount_o <= hcount_o + 1'b1;
      end
    end
  end

  // active area, top left corner of the raster
  assign active_o = (hcount_o < keyer_pkg::COORD_W'(H_ACTIVE)) &&
                    (vcount_o < keyer_pkg::COORD_W'(V_ACTIVE));

  // strobe on the last active pixel of the frame
  assign frame_end_o = (hcount_o == keyer_pkg::COORD_W'(H_ACTIVE - 1)) &&
                       (vcount_o == keyer_pkg::COORD_W'(V_ACTIVE - 1));

endmodule

//--- hw/chroma_key.sv
`timescale 1ns/1ps

module chroma_key (
  input  logic                          clk_pixel,
  input  logic                          recent_reset,
  input  keyer_pkg::rgb565_t            pixel_i,
  input  logic [keyer_pkg::COORD_W-1:0] hcount_i,
  input  logic [keyer_pkg::COORD_W-1:0] vcount_i,
  input  logic                          active_i,
  input  logic                          frame_end_i,
  input  logic [3:0]                    cr_upper_i,
  input  logic [3:0]                    cb_upper_i,
  input  keyer_pkg::view_sel_e          view_sel_i,
  output keyer_pkg::rgb888_t            pixel_o,
  output logic                          player_o,
  output logic [keyer_pkg::COORD_W-1:0] hcount_o,
  output logic [keyer_pkg::COORD_W-1:0] vcount_o,
  output logic                          active_o,
  output logic                          frame_end_o
);

  // widened pixel, carried along to the view mux
  keyer_pkg::rgb888_t rgb_s1, rgb_s2, rgb_s3;
  // chroma products, all positive, signs applied in the sum
  logic [14:0] cr_r, cr_g, cr_b;
  logic [14:0] cb_r, cb_g, cb_b;
  logic signed [16:0] cr_full, cb_full;
  logic signed [9:0] cr_ofs, cb_ofs;
  logic [keyer_pkg::COLOR_W-1:0] cr_val, cb_val;
  logic player_next;
  // position and flags, 4 deep
  logic [keyer_pkg::COORD_W-1:0] hcount_d [4];
  logic [keyer_pkg::COORD_W-1:0] vcount_d [4];
  logic [3:0] active_d;
  logic [3:0] frame_end_d;

  function automatic logic [7:0] clamp8(input logic signed [9:0] v);
    logic [7:0] res;
    if (v < 0) begin
      res = 8'd0;
    end else if (v > 255) begin
      res = 8'd255;
    end else begin
      res = v[7:0];
    end
    return res;
  endfunction

  // ==================================================
  // stage 1 widen, stage 2 multiply
  // ==================================================
  always_ff @(posedge clk_pixel) begin
    // zero-pad the low bits
    rgb_s1 <= {pixel_i.r, 3'b000, pixel_i.g, 2'b00, pixel_i.b, 3'b000};
    rgb_s2 <= rgb_s1;
    // Cr = 112R - 94G - 18B
    cr_r <= rgb_s1.r * 15'd112;
    cr_g <= rgb_s1.g * 15'd94;
    cr_b <= rgb_s1.b * 15'd18;
    // Cb = -38R - 74G + 112B
    cb_r <= rgb_s1.r * 15'd38;
    cb_g <= rgb_s1.g * 15'd74;
    cb_b <= rgb_s1.b * 15'd112;
  end

  // ==================================================
  // stage 3 sum, scale, offset and clamp
  // ==================================================
  assign cr_full = $signed({2'b00, cr_r}) - $signed({2'b00, cr_g}) - $signed({2'b00, cr_b});
  assign cb_full = $signed({2'b00, cb_b}) - $signed({2'b00, cb_r}) - $signed({2'b00, cb_g});
  // top bits of a signed sum give the floor of /256
  assign cr_ofs = $signed(cr_full[16:8]) + 10'sd128;
  assign cb_ofs = $signed(cb_full[16:8]) + 10'sd128;

  always_ff @(posedge clk_pixel) begin
    cr_val <= clamp8(cr_ofs);
    cb_val <= clamp8(cb_ofs);
    rgb_s3 <= rgb_s2;
  end

  // ==================================================
  // stage 4 threshold and view select
  // ==================================================
  // green screen when both chroma values sit at or under the bounds
  assign player_next = active_d[2] &&
                       !((cr_val <= {cr_upper_i, 4'b0000}) && (cb_val <= {cb_upper_i, 4'b0000}));

  always_ff @(posedge clk_pixel) begin
    case (view_sel_i)
      keyer_pkg::VIEW_CAMERA: pixel_o <= rgb_s3;
      keyer_pkg::VIEW_MASK: begin
        pixel_o <= player_next ? keyer_pkg::MASK_ON_COLOR : keyer_pkg::MASK_OFF_COLOR;
      end
      keyer_pkg::VIEW_CHROMA: pixel_o <= {cr_val, cr_val, cr_val};
      default: pixel_o <= keyer_pkg::MASK_OFF_COLOR;
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      player_o <= 1'b0;
      active_d <= '0;
      frame_end_d <= '0;
    end else begin
      player_o <= player_next;
      active_d <= {active_d[2:0], active_i};
      frame_end_d <= {frame_end_d[2:0], frame_end_i};
    end
  end

  // position rides along with the pixel
  always_ff @(posedge clk_pixel) begin
    hcount_d[0] <= hcount_i;
    vcount_d[0] <= vcount_i;
    for (int i = 1; i < 4; i++) begin
      hcount_d[i] <= hcount_d[i-1];
      vcount_d[i] <= vcount_d[i-1];
    end
  end

  assign hcount_o = hcount_d[3];
  assign vcount_o = vcount_d[3];
  assign active_o = active_d[3];
  assign frame_end_o = frame_end_d[3];

endmodule

//--- hw/centroid_tracker.sv
`timescale 1ns/1ps

module centroid_tracker (
  input  logic                          clk_pixel,
  input  logic                          recent_reset,
  input  logic [keyer_pkg::COORD_W-1:0] hcount_i,
  input  logic [keyer_pkg::COORD_W-1:0] vcount_i,
  input  logic                          player_i,
  input  logic                          frame_end_i,
  output logic [keyer_pkg::COORD_W-1:0] com_x_o,
  output logic [keyer_pkg::COORD_W-1:0] com_y_o,
  output logic                          com_valid_o
);

  localparam int SW = keyer_pkg::SUM_W;
  localparam int CNT_W = $clog2(SW);

  // running sums for the current frame
  logic [SW-1:0] x_sum, y_sum, pix_count;
  // sums including the pixel at hand
  logic [SW-1:0] x_total, y_total, count_total;
  keyer_pkg::div_state_e div_state;
  logic [SW-1:0] quo, divisor, y_snap;
  logic [SW:0] rem, rem_sh;
  logic [SW-1:0] quo_next;
  logic ge;
  logic [CNT_W-1:0] bit_cnt;
  logic [keyer_pkg::COORD_W-1:0] x_quo;

  assign x_total = x_sum + (player_i ? SW'(hcount_i) : '0);
  assign y_total = y_sum + (player_i ? SW'(vcount_i) : '0);
  assign count_total = pix_count + SW'(player_i);

  // ==================================================
  // per-frame accumulation
  // ==================================================
  always_ff @(posedge clk_pixel) begin
    if (recent_reset || frame_end_i) begin
      // frame end hands the totals to the divider
      x_sum <= '0;
      y_sum <= '0;
      pix_count <= '0;
    end else begin
      x_sum <= x_total;
      y_sum <= y_total;
      pix_count <= count_total;
    end
  end

  // ==================================================
  // restoring divider, x then y
  // ==================================================
  // shift in the next dividend bit, subtract when it fits
  assign rem_sh = {rem[SW-1:0], quo[SW-1]};
  assign ge = (rem_sh >= {1'b0, divisor});
  assign quo_next = {quo[SW-2:0], ge};

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      div_state <= keyer_pkg::DIV_IDLE;
      com_x_o <= '0;
      com_y_o <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= 1'b0;
      case (div_state)
        keyer_pkg::DIV_IDLE: begin
          // empty frame keeps the last center
          if (frame_end_i && (count_total != '0)) begin
            quo <= x_total;
            rem <= '0;
            divisor <= count_total;
            y_snap <= y_total;
            bit_cnt <= '0;
            div_state <= keyer_pkg::DIV_X;
          end
        end
        keyer_pkg::DIV_X, keyer_pkg::DIV_Y: begin
          rem <= ge ? rem_sh - {1'b0, divisor} : rem_sh;
          quo <= quo_next;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(SW - 1)) begin
            if (div_state == keyer_pkg::DIV_X) begin
              // x done, restart on the y sum
              x_quo <= quo_next[keyer_pkg::COORD_W-1:0];
              quo <= y_snap;
              rem <= '0;
              div_state <= keyer_pkg::DIV_Y;
            end else begin
              div_state <= keyer_pkg::DIV_DONE;
            end
          end
        end
        default: begin
          // quotient fits the coordinate width
          com_x_o <= x_quo;
          com_y_o <= quo[keyer_pkg::COORD_W-1:0];
          com_valid_o <= 1'b1;
          div_state <= keyer_pkg::DIV_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/crosshair_overlay.sv
`timescale 1ns/1ps

module crosshair_overlay (
  input  logic                          clk_pixel,
  input  logic                          recent_reset,
  input  keyer_pkg::rgb888_t            pixel_i,
  input  logic [keyer_pkg::COORD_W-1:0] hcount_i,
  input  logic [keyer_pkg::COORD_W-1:0] vcount_i,
  input  logic                          active_i,
  input  logic [keyer_pkg::COORD_W-1:0] com_x_i,
  input  logic [keyer_pkg::COORD_W-1:0] com_y_i,
  input  logic                          crosshair_en_i,
  output keyer_pkg::rgb888_t            rgb_o,
  output logic [keyer_pkg::COORD_W-1:0] pix_hcount_o,
  output logic [keyer_pkg::COORD_W-1:0] pix_vcount_o,
  output logic                          pix_active_o
);

  // on the center row or column
  logic on_cross;

  assign on_cross = crosshair_en_i && active_i &&
                    ((hcount_i == com_x_i) || (vcount_i == com_y_i));

  // output register, one cycle after the keyed pixel
  always_ff @(posedge clk_pixel) begin
    rgb_o <= on_cross ? keyer_pkg::CROSSHAIR_COLOR : pixel_i;
    pix_hcount_o <= hcount_i;
    pix_vcount_o <= vcount_i;
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      pix_active_o <= 1'b0;
    end else begin
      pix_active_o <= active_i;
    end
  end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 644
) (
  input  logic                          clk_pixel,
  input  logic                          recent_reset,
  input  logic [keyer_pkg::COORD_W-1:0] com_x_i,
  input  logic [keyer_pkg::COORD_W-1:0] com_y_i,
  input  logic                          start_i,
  output logic                          tx_o
);

  localparam int TMR_W = $clog2(CLKS_PER_BIT + 1);
  localparam int BYTE_W = $clog2(keyer_pkg::MSG_BYTES);
  localparam int PAD_W = 16 - keyer_pkg::COORD_W;

  keyer_pkg::uart_state_e uart_state;
  logic [TMR_W-1:0] timer;
  logic bit_end;
  logic [2:0] bit_idx;
  logic [BYTE_W-1:0] byte_cnt;
  // message, sent from the bottom byte up
  logic [8*keyer_pkg::MSG_BYTES-1:0] msg;

  assign bit_end = (timer == TMR_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      uart_state <= keyer_pkg::UART_IDLE;
      timer <= '0;
      byte_cnt <= '0;
      tx_o <= 1'b1;
    end else begin
      timer <= bit_end ? '0 : timer + 1'b1;
      case (uart_state)
        keyer_pkg::UART_IDLE: begin
          timer <= '0;
          tx_o <= 1'b1;
          // a center arriving while busy is dropped
          if (start_i) begin
            msg <= {{PAD_W{1'b0}}, com_y_i, {PAD_W{1'b0}}, com_x_i};
            byte_cnt <= '0;
            tx_o <= 1'b0;
            uart_state <= keyer_pkg::UART_START;
          end
        end
        keyer_pkg::UART_START: begin
          if (bit_end) begin
            bit_idx <= '0;
            tx_o <= msg[0];
            uart_state <= keyer_pkg::UART_DATA;
          end
        end
        keyer_pkg::UART_DATA: begin
          // lsb first, the shift lines up the next byte too
          if (bit_end) begin
            msg <= msg >> 1;
            if (bit_idx == 3'd7) begin
              tx_o <= 1'b1;
              uart_state <= keyer_pkg::UART_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_o <= msg[1];
            end
          end
        end
        default: begin
          if (bit_end) begin
            if (byte_cnt == BYTE_W'(keyer_pkg::MSG_BYTES - 1)) begin
              uart_state <= keyer_pkg::UART_IDLE;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              tx_o <= 1'b0;
              uart_state <= keyer_pkg::UART_START;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- hw/keyer_top.sv
`timescale 1ns/1ps

module keyer_top #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720,
  parameter int H_TOTAL = 1650,
  parameter int V_TOTAL = 750,
  parameter int CLKS_PER_BIT = 644
) (
  input  logic                          clk_pixel,
  input  logic                          recent_reset,
  input  keyer_pkg::rgb565_t            pixel_i,
  input  logic [3:0]                    cr_upper_i,
  input  logic [3:0]                    cb_upper_i,
  input  keyer_pkg::view_sel_e          view_sel_i,
  input  logic                          crosshair_en_i,
  output logic [keyer_pkg::COORD_W-1:0] hcount_o,
  output logic [keyer_pkg::COORD_W-1:0] vcount_o,
  output keyer_pkg::rgb888_t            rgb_o,
  output logic [keyer_pkg::COORD_W-1:0] pix_hcount_o,
  output logic [keyer_pkg::COORD_W-1:0] pix_vcount_o,
  output logic                          pix_active_o,
  output logic [keyer_pkg::COORD_W-1:0] com_x_o,
  output logic [keyer_pkg::COORD_W-1:0] com_y_o,
  output logic                          com_valid_o,
  output logic                          uart_tx_o
);

  // raster flags
  logic active, frame_end;
  // keyed stream, 4 cycles behind the raster
  keyer_pkg::rgb888_t key_pixel;
  logic key_player, key_active, key_frame_end;
  logic [keyer_pkg::COORD_W-1:0] key_hcount, key_vcount;

  video_timing #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)
  ) u_timing (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .hcount_o(hcount_o), .vcount_o(vcount_o),
    .active_o(active), .frame_end_o(frame_end)
  );

  chroma_key u_key (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .pixel_i(pixel_i), .hcount_i(hcount_o), .vcount_i(vcount_o),
    .active_i(active), .frame_end_i(frame_end),
    .cr_upper_i(cr_upper_i), .cb_upper_i(cb_upper_i), .view_sel_i(view_sel_i),
    .pixel_o(key_pixel), .player_o(key_player),
    .hcount_o(key_hcount), .vcount_o(key_vcount),
    .active_o(key_active), .frame_end_o(key_frame_end)
  );

  centroid_tracker u_tracker (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .hcount_i(key_hcount), .vcount_i(key_vcount),
    .player_i(key_player), .frame_end_i(key_frame_end),
    .com_x_o(com_x_o), .com_y_o(com_y_o), .com_valid_o(com_valid_o)
  );

  // crosshair follows the held center
  crosshair_overlay u_overlay (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .pixel_i(key_pixel), .hcount_i(key_hcount), .vcount_i(key_vcount),
    .active_i(key_active), .com_x_i(com_x_o), .com_y_i(com_y_o),
    .crosshair_en_i(crosshair_en_i), .rgb_o(rgb_o),
    .pix_hcount_o(pix_hcount_o), .pix_vcount_o(pix_vcount_o), .pix_active_o(pix_active_o)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .com_x_i(com_x_o), .com_y_i(com_y_o),
    .start_i(com_valid_o), .tx_o(uart_tx_o)
  );

endmodule

//--- tb/tb_keyer_sva.sv
`timescale 1ns/1ps

module tb_keyer_sva (
  input logic clk_pixel,
  input logic recent_reset,
  input logic pulse_i,
  input logic frame_end_i,
  input logic count_zero_i,
  input logic idle_i,
  input logic tx_i
);

  // longest divider run, x pass, y pass and the closing state
  localparam int DIV_SPAN = 2 * keyer_pkg::SUM_W + 4;

  // sticky flag, read by the testbench at the end
  logic failed;

  initial failed = 1'b0;

  // center strobe lasts a single cycle
  pulse_once: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    pulse_i |=> !pulse_i)
    else begin
      $error("center valid stayed high for more than one cycle");
      failed = 1'b1;
    end

  // serializer idle means a high line
  line_idle_high: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    idle_i |-> tx_i)
    else begin
      $error("uart line low while the serializer is idle");
      failed = 1'b1;
    end

  // a frame without player pixels must not produce a center
  empty_frame_quiet: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    (frame_end_i && count_zero_i) |=> !pulse_i [*DIV_SPAN])
    else begin
      $error("center valid after a frame with no player pixels");
      failed = 1'b1;
    end

endmodule

// tracker side, uart inputs tied off
bind centroid_tracker tb_keyer_sva u_sva_tracker (
  .clk_pixel(clk_pixel), .recent_reset(recent_reset),
  .pulse_i(com_valid_o), .frame_end_i(frame_end_i), .count_zero_i(count_total == '0),
  .idle_i(1'b0), .tx_i(1'b1)
);

// uart side, tracker inputs tied off
bind uart_tx tb_keyer_sva u_sva_uart (
  .clk_pixel(clk_pixel), .recent_reset(recent_reset),
  .pulse_i(1'b0), .frame_end_i(1'b0), .count_zero_i(1'b0),
  .idle_i(uart_state == keyer_pkg::UART_IDLE), .tx_i(tx_o)
);

//--- tb/tb_keyer.sv
`timescale 1ns/1ps

module tb_keyer;

  // small raster so a frame runs in about a thousand cycles
  localparam int H_ACTIVE = 32;
  localparam int V_ACTIVE = 24;
  localparam int H_TOTAL = 40;
  localparam int V_TOTAL = 28;
  localparam int CLKS_PER_BIT = 4;
  localparam int CW = keyer_pkg::COORD_W;
  localparam int NUM_FRAMES = 10;
  localparam int SEED = 32'he5d2;
  localparam longint TIMEOUT_NS = longint'(NUM_FRAMES + 2) * H_TOTAL * V_TOTAL * 100;

  logic clk_pixel;
  logic recent_reset;
  keyer_pkg::rgb565_t pixel_i;
  logic [3:0] cr_upper_i;
  logic [3:0] cb_upper_i;
  keyer_pkg::view_sel_e view_sel_i;
  logic crosshair_en_i;
  logic [CW-1:0] hcount_o, vcount_o, pix_hcount_o, pix_vcount_o, com_x_o, com_y_o;
  keyer_pkg::rgb888_t rgb_o;
  logic pix_active_o, com_valid_o, uart_tx_o;

  // scene of the frame on screen
  keyer_pkg::rgb565_t scene [V_ACTIVE][H_ACTIVE];
  string test_name;
  int frame_idx;
  // center the DUT holds during this frame
  int held_x, held_y;
  // pending centers {x, y} and uart words {y, x}
  logic [31:0] center_q [$];
  logic [31:0] msg_q [$];
  // active output pixels seen in the current frame
  int pix_seen;
  // raster positions of the last 5 cycles, newest first
  logic [CW-1:0] h_hist [5];
  logic [CW-1:0] v_hist [5];

  keyer_top #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) UUT (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset), .pixel_i(pixel_i),
    .cr_upper_i(cr_upper_i), .cb_upper_i(cb_upper_i), .view_sel_i(view_sel_i),
    .crosshair_en_i(crosshair_en_i), .hcount_o(hcount_o), .vcount_o(vcount_o),
    .rgb_o(rgb_o), .pix_hcount_o(pix_hcount_o), .pix_vcount_o(pix_vcount_o),
    .pix_active_o(pix_active_o), .com_x_o(com_x_o), .com_y_o(com_y_o),
    .com_valid_o(com_valid_o), .uart_tx_o(uart_tx_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #50 clk_pixel = ~clk_pixel;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    stop_on_error($sformatf("[FAIL] %s expected %0h actual %0h", test, exp_v, act_v));
  endtask

  // ==================================================
  // reference model
  // ==================================================

  // low bits padded with zeros
  function automatic keyer_pkg::rgb888_t widen(input keyer_pkg::rgb565_t p);
    keyer_pkg::rgb888_t c;
    c.r = 8'(p.r * 8);
    c.g = 8'(p.g * 4);
    c.b = 8'(p.b * 8);
    return c;
  endfunction

  // 128 + floor(v / 256), clamped to a byte
  function automatic int chroma(input int v);
    int q;
    q = 128 + (v >>> 8);
    if (q < 0) q = 0;
    if (q > 255) q = 255;
    return q;
  endfunction

  function automatic int ref_cr(input keyer_pkg::rgb565_t p);
    keyer_pkg::rgb888_t c;
    c = widen(p);
    return chroma(112 * int'(c.r) - 94 * int'(c.g) - 18 * int'(c.b));
  endfunction

  function automatic int ref_cb(input keyer_pkg::rgb565_t p);
    keyer_pkg::rgb888_t c;
    c = widen(p);
    return chroma(112 * int'(c.b) - 38 * int'(c.r) - 74 * int'(c.g));
  endfunction

  // player unless both chroma values sit at or under the bounds
  function automatic bit is_player(input keyer_pkg::rgb565_t p);
    return !((ref_cr(p) <= int'(cr_upper_i) * 16) && (ref_cb(p) <= int'(cb_upper_i) * 16));
  endfunction

  function automatic keyer_pkg::rgb888_t expected_rgb(input int x, input int y);
    int cr;
    if (crosshair_en_i && (x == held_x || y == held_y)) return keyer_pkg::CROSSHAIR_COLOR;
    case (view_sel_i)
      keyer_pkg::VIEW_CAMERA: return widen(scene[y][x]);
      keyer_pkg::VIEW_MASK: begin
        return is_player(scene[y][x]) ? keyer_pkg::MASK_ON_COLOR : keyer_pkg::MASK_OFF_COLOR;
      end
      keyer_pkg::VIEW_CHROMA: begin
        cr = ref_cr(scene[y][x]);
        return {8'(cr), 8'(cr), 8'(cr)};
      end
      default: return keyer_pkg::MASK_OFF_COLOR;
    endcase
  endfunction

  task automatic scene_centroid(output int count, output int cx, output int cy);
    int sx, sy;
    count = 0;
    sx = 0;
    sy = 0;
    cx = 0;
    cy = 0;
    for (int y = 0; y < V_ACTIVE; y++) begin
      for (int x = 0; x < H_ACTIVE; x++) begin
        if (is_player(scene[y][x])) begin
          count++;
          sx += x;
          sy += y;
        end
      end
    end
    if (count != 0) begin
      cx = sx / count;
      cy = sy / count;
    end
  endtask

  // ==================================================
  // scenes and frame schedule
  // ==================================================

  // green background, optional block of reddish pixels
  task automatic build_scene(input bit with_player);
    int x0, y0, w, h;
    w = $urandom_range(10, 2);
    h = $urandom_range(8, 2);
    x0 = $urandom_range(H_ACTIVE - w, 0);
    y0 = $urandom_range(V_ACTIVE - h, 0);
    for (int y = 0; y < V_ACTIVE; y++) begin
      for (int x = 0; x < H_ACTIVE; x++) begin
        if (with_player && x >= x0 && x < x0 + w && y >= y0 && y < y0 + h) begin
          scene[y][x] = {5'($urandom_range(31, 24)), 6'($urandom_range(15, 0)),
                         5'($urandom_range(7, 0))};
        end else begin
          scene[y][x] = {5'($urandom_range(7, 0)), 6'($urandom_range(63, 40)),
                         5'($urandom_range(7, 0))};
        end
      end
    end
  endtask

  task automatic setup_frame(input int n);
    cr_upper_i = 4'd8;
    cb_upper_i = 4'd8;
    crosshair_en_i = 1'b0;
    view_sel_i = keyer_pkg::VIEW_CAMERA;
    if (n >= 1 && n <= 3) begin
      test_name = "mask view";
      view_sel_i = keyer_pkg::VIEW_MASK;
      cr_upper_i = 4'($urandom_range(15, 0));
      cb_upper_i = 4'($urandom_range(15, 0));
      build_scene(1'b1);
    end else if (n == 4) begin
      test_name = "chroma view";
      view_sel_i = keyer_pkg::VIEW_CHROMA;
      build_scene(1'b1);
    end else if (n == 5) begin
      test_name = "blank view";
      view_sel_i = keyer_pkg::VIEW_BLANK;
      build_scene(1'b1);
    end else if (n == 6) begin
      test_name = "empty frame";
      build_scene(1'b0);
    end else if (n >= 7) begin
      // same scene from frame 7 on
      test_name = "crosshair";
      crosshair_en_i = 1'b1;
      if (n == 7) build_scene(1'b1);
    end else begin
      test_name = "camera view";
      build_scene(1'b1);
    end
  endtask

  // start of vertical blank, the divider is still busy here
  task automatic close_frame();
    int count, cx, cy;
    assert (center_q.size() == 0 && msg_q.size() == 0)
      else stop_on_error("a center or its uart message from the last frame never came");
    assert (com_x_o == CW'(held_x) && com_y_o == CW'(held_y))
      else report_mismatch({test_name, " held center"}, {16'(held_x), 16'(held_y)},
                           {16'(com_x_o), 16'(com_y_o)});
    assert (uart_tx_o) else stop_on_error("uart line is not idle between messages");
    // every active position of the frame came out exactly once
    assert (pix_seen == H_ACTIVE * V_ACTIVE)
      else report_mismatch({test_name, " active pixel count"}, H_ACTIVE * V_ACTIVE, pix_seen);
    pix_seen = 0;
    scene_centroid(count, cx, cy);
    if (count != 0) begin
      center_q.push_back({16'(cx), 16'(cy)});
      msg_q.push_back({16'(cy), 16'(cx)});
      held_x = cx;
      held_y = cy;
    end
    frame_idx++;
    setup_frame(frame_idx);
  endtask

  // ==================================================
  // stimulus, drives on the falling edge
  // ==================================================
  initial begin
    int exp_h;
    int exp_v;
    void'($urandom(SEED));
    recent_reset = 1'b1;
    pixel_i = '0;
    held_x = 0;
    held_y = 0;
    frame_idx = 0;
    pix_seen = 0;
    exp_h = 0;
    exp_v = 0;
    setup_frame(0);
    repeat (5) @(posedge clk_pixel);
    @(negedge clk_pixel);
    recent_reset = 1'b0;
    // run the frames, then let the last center and message drain
    while (frame_idx < NUM_FRAMES || center_q.size() != 0 || msg_q.size() != 0) begin
      // raster walks from 0,0 and wraps at the totals
      assert (hcount_o == CW'(exp_h) && vcount_o == CW'(exp_v))
        else report_mismatch("raster position", {16'(exp_h), 16'(exp_v)},
                             {16'(hcount_o), 16'(vcount_o)});
      if (hcount_o == 0 && vcount_o == CW'(V_ACTIVE)) close_frame();
      if (hcount_o < H_ACTIVE && vcount_o < V_ACTIVE) begin
        pixel_i = scene[vcount_o][hcount_o];
      end else begin
        pixel_i = '0;
      end
      exp_h = (exp_h == H_TOTAL - 1) ? 0 : exp_h + 1;
      if (exp_h == 0) exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
      @(negedge clk_pixel);
    end
    assert (uart_tx_o) else stop_on_error("uart line low after the last message");
    if (UUT.u_tracker.u_sva_tracker.failed || UUT.u_uart.u_sva_uart.failed) begin
      stop_on_error("a bound assertion in the DUT failed");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // ==================================================
  // checkers
  // ==================================================

  // output pixel against the view rule and its position against the raster 5 cycles back
  always @(negedge clk_pixel) begin : pixel_check
    keyer_pkg::rgb888_t exp_rgb;
    if (!recent_reset && pix_active_o) begin
      assert (pix_hcount_o == h_hist[4] && pix_vcount_o == v_hist[4])
        else report_mismatch({test_name, " output position"},
                             {16'(h_hist[4]), 16'(v_hist[4])},
                             {16'(pix_hcount_o), 16'(pix_vcount_o)});
      pix_seen++;
      exp_rgb = expected_rgb(pix_hcount_o, pix_vcount_o);
      assert (rgb_o == exp_rgb)
        else report_mismatch($sformatf("%s pixel (%0d,%0d)", test_name, pix_hcount_o,
                                       pix_vcount_o), exp_rgb, rgb_o);
    end
    for (int i = 4; i > 0; i--) begin
      h_hist[i] = h_hist[i-1];
      v_hist[i] = v_hist[i-1];
    end
    h_hist[0] = hcount_o;
    v_hist[0] = vcount_o;
  end

  // center pulse against the reference centroid
  always @(negedge clk_pixel) begin : center_check
    logic [31:0] exp_c;
    if (!recent_reset && com_valid_o) begin
      assert (center_q.size() != 0)
        else stop_on_error("center pulse after a frame with no player pixels");
      exp_c = center_q.pop_front();
      assert ({16'(com_x_o), 16'(com_y_o)} == exp_c)
        else report_mismatch({test_name, " center"}, exp_c, {16'(com_x_o), 16'(com_y_o)});
    end
  end

  // 8N1 decoder, samples mid bit
  initial begin : uart_decode
    logic [7:0] rx_byte;
    logic [31:0] rx_msg;
    logic [31:0] exp_msg;
    forever begin
      for (int b = 0; b < keyer_pkg::MSG_BYTES; b++) begin
        @(negedge clk_pixel);
        while (recent_reset || uart_tx_o !== 1'b0) @(negedge clk_pixel);
        repeat (CLKS_PER_BIT / 2) @(negedge clk_pixel);
        assert (!uart_tx_o) else stop_on_error("uart start bit ended early");
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk_pixel);
          rx_byte[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk_pixel);
        assert (uart_tx_o) else stop_on_error("uart stop bit missing");
        rx_msg[8*b +: 8] = rx_byte;
      end
      assert (msg_q.size() != 0) else stop_on_error("uart message without a new center");
      exp_msg = msg_q.pop_front();
      assert (rx_msg == exp_msg) else report_mismatch("uart message", exp_msg, rx_msg);
    end
  end

  // watchdog sized from the frame count
  initial begin : watchdog
    #(TIMEOUT_NS);
    stop_on_error("timeout: the run did not finish in the expected time");
  end

endmodule

//--- verilog.f
hw/keyer_pkg.sv
hw/video_timing.sv
hw/chroma_key.sv
hw/centroid_tracker.sv
hw/crosshair_overlay.sv
hw/uart_tx.sv
hw/keyer_top.sv
tb/tb_keyer_sva.sv
tb/tb_keyer.sv
